/* design/hart_pkg.sv */
package hart_pkg;

  typedef logic [31:0] word_t;     // data, address and instruction word
  typedef logic [4:0]  reg_addr_t; // architectural register index
  typedef logic [6:0]  opcode_t;   // major opcode, inst[6:0]
  typedef logic [3:0]  alu_op_t;   // ALU operation select
  typedef logic [0:0]  wb_sel_t;   // writeback source select

  // major opcodes of the kept subset
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011; // only ebreak is honoured

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLT    = 4'd5;
  localparam alu_op_t ALU_SLTU   = 4'd6;
  localparam alu_op_t ALU_SLL    = 4'd7;
  localparam alu_op_t ALU_SRL    = 4'd8;
  localparam alu_op_t ALU_SRA    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10; // lui hands the U-immediate straight through

  localparam wb_sel_t WB_ALU = 1'b0;
  localparam wb_sel_t WB_MEM = 1'b1; // loads write the dmem word back

  localparam word_t EBREAK_INST = 32'h00100073;

  // true when the opcode actually reads rs1
  function automatic logic uses_rs1(input opcode_t opc);
    return (opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LOAD) ||
           (opc == OPC_STORE);
  endfunction

  // only register-register ops and stores read rs2
  function automatic logic uses_rs2(input opcode_t opc);
    return (opc == OPC_OP) || (opc == OPC_STORE);
  endfunction

endpackage

/* design/hart_fetch.sv */
module hart_fetch #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_stall,      // hazard hold, freezes PC and IF/ID
  input  hart_pkg::word_t i_imem_rdata, // instruction at o_imem_raddr, same cycle
  output hart_pkg::word_t o_imem_raddr,
  output hart_pkg::word_t o_id_pc,
  output hart_pkg::word_t o_id_inst,
  output logic            o_id_valid
);

  hart_pkg::word_t pc;

  assign o_imem_raddr = pc; // the PC addresses imem directly

  // there are no branches, so the PC only ever steps by one word
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc         <= RESET_ADDR;
      o_id_valid <= 1'b0; // ID starts empty
    end else if (!i_stall) begin
      pc         <= pc + 32'd4;
      o_id_valid <= 1'b1; // from the first fetch on ID always holds a real instruction
    end
  end

  // the IF/ID payload is held together with the PC under stall
  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_id_pc   <= pc;
      o_id_inst <= i_imem_rdata;
    end
  end

endmodule

/* design/hart_regfile.sv */
module hart_regfile (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::reg_addr_t i_rs1_raddr,
  input  hart_pkg::reg_addr_t i_rs2_raddr,
  input  logic                i_rd_wen,   // write port, driven from the WB stage
  input  hart_pkg::reg_addr_t i_rd_waddr,
  input  hart_pkg::word_t     i_rd_wdata,
  output hart_pkg::word_t     o_rs1_rdata,
  output hart_pkg::word_t     o_rs2_rdata
);

  hart_pkg::word_t regs [1:31]; // x0 is not stored at all

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd_waddr != '0)) begin
      regs[i_rd_waddr] <= i_rd_wdata; // writes to x0 are dropped here
    end
  end

  // a write in WB is passed straight to ID in the same cycle, so a
  // dependence three stages apart never needs a stall
  always_comb begin
    if (i_rs1_raddr == '0) o_rs1_rdata = '0;
    else if (i_rd_wen && (i_rd_waddr == i_rs1_raddr)) o_rs1_rdata = i_rd_wdata;
    else o_rs1_rdata = regs[i_rs1_raddr];
  end

  always_comb begin
    if (i_rs2_raddr == '0) o_rs2_rdata = '0;
    else if (i_rd_wen && (i_rd_waddr == i_rs2_raddr)) o_rs2_rdata = i_rd_wdata;
    else o_rs2_rdata = regs[i_rs2_raddr];
  end

endmodule

/* design/hart_hazard.sv */
module hart_hazard (
  input  logic                i_id_valid,
  input  hart_pkg::reg_addr_t i_id_rs1,   // already zero when the source is unused
  input  hart_pkg::reg_addr_t i_id_rs2,
  input  hart_pkg::reg_addr_t i_ex_rd,
  input  hart_pkg::reg_addr_t i_mem_rd,
  input  logic                i_ex_wen,   // EX holds a valid register-writing instruction
  input  logic                i_mem_wen,
  output logic                o_stall
);

  logic rs1_hit;
  logic rs2_hit;

  // without forwarding a producer in EX or MEM has not reached the regfile yet
  assign rs1_hit = (i_id_rs1 != '0) &&
                   ((i_ex_wen && (i_ex_rd == i_id_rs1)) ||
                    (i_mem_wen && (i_mem_rd == i_id_rs1)));

  assign rs2_hit = (i_id_rs2 != '0) &&
                   ((i_ex_wen && (i_ex_rd == i_id_rs2)) ||
                    (i_mem_wen && (i_mem_rd == i_id_rs2)));

  // holds until the producer passes into WB, where the regfile write-through covers it
  assign o_stall = i_id_valid && (rs1_hit || rs2_hit);

endmodule

/* design/hart_decode.sv */
module hart_decode (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_stall,   // turns the ID/EX load into a bubble
  input  hart_pkg::word_t     i_pc,
  input  hart_pkg::word_t     i_inst,
  input  logic                i_valid,
  input  hart_pkg::word_t     i_rs1_rdata,
  input  hart_pkg::word_t     i_rs2_rdata,
  output hart_pkg::reg_addr_t o_rs1,     // zero when the opcode does not read it
  output hart_pkg::reg_addr_t o_rs2,
  output logic                o_ex_valid,
  output logic                o_ex_wen,  // writes rd
  output logic                o_ex_ren,  // load
  output logic                o_ex_mwen, // store
  output logic                o_ex_halt,
  output hart_pkg::alu_op_t   o_ex_alu_op,
  output hart_pkg::wb_sel_t   o_ex_wb_sel,
  output hart_pkg::word_t     o_ex_a,
  output hart_pkg::word_t     o_ex_b,
  output hart_pkg::word_t     o_ex_store_data,
  output hart_pkg::word_t     o_ex_pc,
  output hart_pkg::word_t     o_ex_inst,
  output hart_pkg::reg_addr_t o_ex_rd
);

  hart_pkg::opcode_t opcode;
  hart_pkg::alu_op_t alu_op;
  hart_pkg::word_t   imm_i, imm_s, imm_u, operand_b;
  logic [2:0]        funct3;
  logic              alt;        // inst[30] picks sub and sra
  logic              writes_rd, is_load, is_store;

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign alt       = i_inst[30];
  assign is_load   = (opcode == hart_pkg::OPC_LOAD);
  assign is_store  = (opcode == hart_pkg::OPC_STORE);
  assign writes_rd = (opcode == hart_pkg::OPC_OP) || (opcode == hart_pkg::OPC_OP_IMM) ||
                     (opcode == hart_pkg::OPC_LUI) || is_load;

  assign o_rs1 = hart_pkg::uses_rs1(opcode) ? i_inst[19:15] : '0;
  assign o_rs2 = hart_pkg::uses_rs2(opcode) ? i_inst[24:20] : '0;

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_u = {i_inst[31:12], 12'b0};

  always_comb begin
    alu_op = hart_pkg::ALU_ADD; // loads and stores add base and offset
    if (opcode == hart_pkg::OPC_LUI) begin
      alu_op = hart_pkg::ALU_PASS_B;
    end else if ((opcode == hart_pkg::OPC_OP) || (opcode == hart_pkg::OPC_OP_IMM)) begin
      case (funct3)
        3'b000: alu_op = (opcode == hart_pkg::OPC_OP && alt) ? hart_pkg::ALU_SUB
                                                             : hart_pkg::ALU_ADD;
        3'b001: alu_op = hart_pkg::ALU_SLL;
        3'b010: alu_op = hart_pkg::ALU_SLT;
        3'b011: alu_op = hart_pkg::ALU_SLTU;
        3'b100: alu_op = hart_pkg::ALU_XOR;
        3'b101: alu_op = alt ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL; // srai shares bit 30
        3'b110: alu_op = hart_pkg::ALU_OR;
        default: alu_op = hart_pkg::ALU_AND;
      endcase
    end
  end

  always_comb begin
    case (opcode)
      hart_pkg::OPC_OP:    operand_b = i_rs2_rdata;
      hart_pkg::OPC_STORE: operand_b = imm_s;
      hart_pkg::OPC_LUI:   operand_b = imm_u;
      default:             operand_b = imm_i; // op-imm and loads
    endcase
  end

  // a stall loads a bubble into the ID/EX controls
  always_ff @(posedge i_clk) begin
    if (i_rst || i_stall) begin
      o_ex_valid <= 1'b0;
      o_ex_wen   <= 1'b0;
      o_ex_ren   <= 1'b0;
      o_ex_mwen  <= 1'b0;
      o_ex_halt  <= 1'b0;
    end else begin
      o_ex_valid <= i_valid;
      o_ex_wen   <= i_valid && writes_rd;
      o_ex_ren   <= i_valid && is_load;
      o_ex_mwen  <= i_valid && is_store;
      o_ex_halt  <= i_valid && (i_inst == hart_pkg::EBREAK_INST);
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_alu_op     <= alu_op;
    o_ex_wb_sel     <= is_load ? hart_pkg::WB_MEM : hart_pkg::WB_ALU;
    o_ex_a          <= i_rs1_rdata; // reads zero through x0 when rs1 is unused
    o_ex_b          <= operand_b;
    o_ex_store_data <= i_rs2_rdata;
    o_ex_pc         <= i_pc;
    o_ex_inst       <= i_inst;
    o_ex_rd         <= writes_rd ? i_inst[11:7] : '0; // stores and ebreak report rd zero
  end

endmodule

/* design/hart_execute.sv */
module hart_execute (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  logic                i_wen,
  input  logic                i_ren,
  input  logic                i_mwen,
  input  logic                i_halt,
  input  hart_pkg::alu_op_t   i_alu_op,
  input  hart_pkg::wb_sel_t   i_wb_sel,
  input  hart_pkg::word_t     i_a,
  input  hart_pkg::word_t     i_b,
  input  hart_pkg::word_t     i_store_data,
  input  hart_pkg::word_t     i_pc,
  input  hart_pkg::word_t     i_inst,
  input  hart_pkg::reg_addr_t i_rd,
  output logic                o_mem_valid,
  output logic                o_mem_wen,
  output logic                o_mem_ren,
  output logic                o_mem_mwen,
  output logic                o_mem_halt,
  output hart_pkg::wb_sel_t   o_mem_wb_sel,
  output hart_pkg::word_t     o_mem_result,   // ALU value, or the address of a load/store
  output hart_pkg::word_t     o_mem_store_data,
  output hart_pkg::word_t     o_mem_pc,
  output hart_pkg::word_t     o_mem_inst,
  output hart_pkg::reg_addr_t o_mem_rd,
  output hart_pkg::reg_addr_t o_ex_rd,        // EX producer, seen by the hazard unit
  output logic                o_ex_wen
);

  hart_pkg::word_t result;
  logic [4:0]      shamt;

  assign shamt    = i_b[4:0]; // register shifts use only the low five bits of rs2
  assign o_ex_rd  = i_rd;
  assign o_ex_wen = i_wen;   // decode has gated it with valid already

  always_comb begin
    case (i_alu_op)
      hart_pkg::ALU_SUB:  result = i_a - i_b;
      hart_pkg::ALU_AND:  result = i_a & i_b;
      hart_pkg::ALU_OR:   result = i_a | i_b;
      hart_pkg::ALU_XOR:  result = i_a ^ i_b;
      hart_pkg::ALU_SLT:  result = {31'b0, $signed(i_a) < $signed(i_b)};
      hart_pkg::ALU_SLTU: result = {31'b0, i_a < i_b};
      hart_pkg::ALU_SLL:  result = i_a << shamt;
      hart_pkg::ALU_SRL:  result = i_a >> shamt;
      hart_pkg::ALU_SRA:  result = $unsigned($signed(i_a) >>> shamt);
      hart_pkg::ALU_PASS_B: result = i_b;
      default:            result = i_a + i_b; // add, and base plus offset for memory ops
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_valid <= 1'b0;
      o_mem_wen   <= 1'b0;
      o_mem_ren   <= 1'b0;
      o_mem_mwen  <= 1'b0;
      o_mem_halt  <= 1'b0;
    end else begin
      o_mem_valid <= i_valid;
      o_mem_wen   <= i_wen;
      o_mem_ren   <= i_ren;
      o_mem_mwen  <= i_mwen;
      o_mem_halt  <= i_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    o_mem_wb_sel     <= i_wb_sel;
    o_mem_result     <= result;
    o_mem_store_data <= i_store_data;
    o_mem_pc         <= i_pc;
    o_mem_inst       <= i_inst;
    o_mem_rd         <= i_rd;
  end

endmodule

/* design/hart_mem_wb.sv */
module hart_mem_wb (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  logic                i_wen,
  input  logic                i_ren,
  input  logic                i_mwen,
  input  logic                i_halt,
  input  hart_pkg::wb_sel_t   i_wb_sel,
  input  hart_pkg::word_t     i_result,
  input  hart_pkg::word_t     i_store_data,
  input  hart_pkg::word_t     i_pc,
  input  hart_pkg::word_t     i_inst,
  input  hart_pkg::reg_addr_t i_rd,
  input  hart_pkg::word_t     i_dmem_rdata,   // valid in the same cycle as ren
  output hart_pkg::word_t     o_dmem_addr,
  output hart_pkg::word_t     o_dmem_wdata,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  output hart_pkg::reg_addr_t o_mem_rd,       // MEM producer, seen by the hazard unit
  output logic                o_mem_wen,
  output logic                o_rd_wen,       // regfile write port from WB
  output hart_pkg::reg_addr_t o_rd_waddr,
  output hart_pkg::word_t     o_rd_wdata,
  output logic                o_retire_valid,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output hart_pkg::reg_addr_t o_retire_rs1_raddr,
  output hart_pkg::reg_addr_t o_retire_rs2_raddr,
  output hart_pkg::reg_addr_t o_retire_rd_waddr
);

  hart_pkg::wb_sel_t   wb_sel;
  hart_pkg::word_t     wb_result, wb_load_data, wb_pc, wb_inst;
  hart_pkg::reg_addr_t wb_rd;
  logic                wb_valid, wb_wen, wb_halt;

  // only full-word accesses remain, so the low address bits are dropped
  assign o_dmem_addr  = {i_result[31:2], 2'b00};
  assign o_dmem_wdata = i_store_data;
  assign o_dmem_ren   = i_valid && i_ren; // ren and wen come from different opcodes
  assign o_dmem_wen   = i_valid && i_mwen;
  assign o_mem_rd     = i_rd;
  assign o_mem_wen    = i_wen;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid <= 1'b0;
      wb_wen   <= 1'b0;
      wb_halt  <= 1'b0;
    end else begin
      wb_valid <= i_valid;
      wb_wen   <= i_wen;
      wb_halt  <= i_halt;
    end
  end

  // load data is captured here, since dmem answers only while ren is high
  always_ff @(posedge i_clk) begin
    wb_sel       <= i_wb_sel;
    wb_result    <= i_result;
    wb_load_data <= i_dmem_rdata;
    wb_pc        <= i_pc;
    wb_inst      <= i_inst;
    wb_rd        <= i_rd;
  end

  assign o_rd_wen   = wb_wen;
  assign o_rd_waddr = wb_rd;
  assign o_rd_wdata = (wb_sel == hart_pkg::WB_MEM) ? wb_load_data : wb_result;

  // the instruction in WB is the one that retires
  assign o_retire_valid     = wb_valid;
  assign o_retire_halt      = wb_halt;
  assign o_retire_inst      = wb_inst;
  assign o_retire_pc        = wb_pc;
  assign o_retire_rd_waddr  = wb_rd;
  assign o_retire_rd_wdata  = o_rd_wdata;
  assign o_retire_rs1_raddr = hart_pkg::uses_rs1(wb_inst[6:0]) ? wb_inst[19:15] : '0;
  assign o_retire_rs2_raddr = hart_pkg::uses_rs2(wb_inst[6:0]) ? wb_inst[24:20] : '0;

endmodule

/* design/hart_top.sv */
module hart_top #(
  parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::word_t     i_imem_rdata,
  input  hart_pkg::word_t     i_dmem_rdata,
  output hart_pkg::word_t     o_imem_raddr,
  output hart_pkg::word_t     o_dmem_addr,
  output hart_pkg::word_t     o_dmem_wdata,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  output logic                o_retire_valid,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output hart_pkg::reg_addr_t o_retire_rs1_raddr,
  output hart_pkg::reg_addr_t o_retire_rs2_raddr,
  output hart_pkg::reg_addr_t o_retire_rd_waddr
);

  // IF/ID and hazard
  hart_pkg::word_t     id_pc, id_inst, rs1_rdata, rs2_rdata;
  hart_pkg::reg_addr_t id_rs1, id_rs2;
  logic                id_valid, stall;
  // ID/EX
  hart_pkg::word_t     ex_a, ex_b, ex_store_data, ex_pc, ex_inst;
  hart_pkg::alu_op_t   ex_alu_op;
  hart_pkg::wb_sel_t   ex_wb_sel;
  hart_pkg::reg_addr_t ex_rd, hz_ex_rd;
  logic                ex_valid, ex_wen, ex_ren, ex_mwen, ex_halt, hz_ex_wen;
  // EX/MEM
  hart_pkg::word_t     mem_result, mem_store_data, mem_pc, mem_inst;
  hart_pkg::wb_sel_t   mem_wb_sel;
  hart_pkg::reg_addr_t mem_rd, hz_mem_rd;
  logic                mem_valid, mem_wen, mem_ren, mem_mwen, mem_halt, hz_mem_wen;
  // WB write port
  hart_pkg::word_t     rd_wdata;
  hart_pkg::reg_addr_t rd_waddr;
  logic                rd_wen;

  hart_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch (
    .i_clk, .i_rst, .i_stall(stall), .i_imem_rdata, .o_imem_raddr,
    .o_id_pc(id_pc), .o_id_inst(id_inst), .o_id_valid(id_valid)
  );

  hart_regfile u_regfile (
    .i_clk, .i_rst, .i_rs1_raddr(id_rs1), .i_rs2_raddr(id_rs2),
    .i_rd_wen(rd_wen), .i_rd_waddr(rd_waddr), .i_rd_wdata(rd_wdata),
    .o_rs1_rdata(rs1_rdata), .o_rs2_rdata(rs2_rdata)
  );

  hart_hazard u_hazard (
    .i_id_valid(id_valid), .i_id_rs1(id_rs1), .i_id_rs2(id_rs2),
    .i_ex_rd(hz_ex_rd), .i_mem_rd(hz_mem_rd), .i_ex_wen(hz_ex_wen), .i_mem_wen(hz_mem_wen),
    .o_stall(stall)
  );

  hart_decode u_decode (
    .i_clk, .i_rst, .i_stall(stall), .i_pc(id_pc), .i_inst(id_inst), .i_valid(id_valid),
    .i_rs1_rdata(rs1_rdata), .i_rs2_rdata(rs2_rdata), .o_rs1(id_rs1), .o_rs2(id_rs2),
    .o_ex_valid(ex_valid), .o_ex_wen(ex_wen), .o_ex_ren(ex_ren), .o_ex_mwen(ex_mwen),
    .o_ex_halt(ex_halt), .o_ex_alu_op(ex_alu_op), .o_ex_wb_sel(ex_wb_sel),
    .o_ex_a(ex_a), .o_ex_b(ex_b), .o_ex_store_data(ex_store_data),
    .o_ex_pc(ex_pc), .o_ex_inst(ex_inst), .o_ex_rd(ex_rd)
  );

  hart_execute u_execute (
    .i_clk, .i_rst, .i_valid(ex_valid), .i_wen(ex_wen), .i_ren(ex_ren), .i_mwen(ex_mwen),
    .i_halt(ex_halt), .i_alu_op(ex_alu_op), .i_wb_sel(ex_wb_sel), .i_a(ex_a), .i_b(ex_b),
    .i_store_data(ex_store_data), .i_pc(ex_pc), .i_inst(ex_inst), .i_rd(ex_rd),
    .o_mem_valid(mem_valid), .o_mem_wen(mem_wen), .o_mem_ren(mem_ren),
    .o_mem_mwen(mem_mwen), .o_mem_halt(mem_halt), .o_mem_wb_sel(mem_wb_sel),
    .o_mem_result(mem_result), .o_mem_store_data(mem_store_data), .o_mem_pc(mem_pc),
    .o_mem_inst(mem_inst), .o_mem_rd(mem_rd), .o_ex_rd(hz_ex_rd), .o_ex_wen(hz_ex_wen)
  );

  hart_mem_wb u_mem_wb (
    .i_clk, .i_rst, .i_valid(mem_valid), .i_wen(mem_wen), .i_ren(mem_ren),
    .i_mwen(mem_mwen), .i_halt(mem_halt), .i_wb_sel(mem_wb_sel), .i_result(mem_result),
    .i_store_data(mem_store_data), .i_pc(mem_pc), .i_inst(mem_inst), .i_rd(mem_rd),
    .i_dmem_rdata, .o_dmem_addr, .o_dmem_wdata, .o_dmem_ren, .o_dmem_wen,
    .o_mem_rd(hz_mem_rd), .o_mem_wen(hz_mem_wen),
    .o_rd_wen(rd_wen), .o_rd_waddr(rd_waddr), .o_rd_wdata(rd_wdata),
    .o_retire_valid, .o_retire_halt, .o_retire_inst, .o_retire_pc, .o_retire_rd_wdata,
    .o_retire_rs1_raddr, .o_retire_rs2_raddr, .o_retire_rd_waddr
  );

endmodule

/* testbench/tb_hart.sv */
module tb_hart;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          HALF_PERIOD  = 20;
  localparam int          RESET_CYCLES = 16;
  localparam int          NUM_INSTS    = 48; // the last one is ebreak
  localparam int          TIMEOUT      = RESET_CYCLES + NUM_INSTS * 3 + 40;
  localparam logic [31:0] RESET_ADDR   = 32'h0000_0000;
  localparam logic [31:0] SEED         = 32'd43712;
  localparam logic [31:0] NOP_WORD     = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [31:0] EBREAK_WORD  = 32'h0010_0073;
  localparam logic [6:0]  OP_REG = 7'b0110011;
  localparam logic [6:0]  OP_IMM = 7'b0010011;
  localparam logic [6:0]  OP_LUI = 7'b0110111;
  localparam logic [6:0]  OP_LOAD = 7'b0000011;
  localparam logic [6:0]  OP_STORE = 7'b0100011;

  // what one instruction should show on the retire port
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        halt;
    logic        is_store;
    logic [31:0] st_addr;
    logic [31:0] st_data;
  } retire_t;

  logic        clk, i_rst;
  logic [31:0] i_imem_rdata, i_dmem_rdata, o_imem_raddr, o_dmem_addr, o_dmem_wdata;
  logic        o_dmem_ren, o_dmem_wen, o_retire_valid, o_retire_halt;
  logic [31:0] o_retire_inst, o_retire_pc, o_retire_rd_wdata;
  logic [4:0]  o_retire_rs1_raddr, o_retire_rs2_raddr, o_retire_rd_waddr;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:63];       // words at byte 0x100 upward, written by the DUT
  logic [31:0] model_dmem [0:63]; // same window as seen by the reference model
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc, rng_state;
  logic [31:0] store_addr_q [$];  // dmem writes waiting for their store to retire
  logic [31:0] store_data_q [$];
  retire_t     expected;
  logic        halt_seen;
  int          errors, checks, retired, cycles;

  hart_top #(.RESET_ADDR(RESET_ADDR)) DUT (
    .i_clk(clk), .i_rst, .i_imem_rdata, .i_dmem_rdata, .o_imem_raddr, .o_dmem_addr,
    .o_dmem_wdata, .o_dmem_ren, .o_dmem_wen, .o_retire_valid, .o_retire_halt,
    .o_retire_inst, .o_retire_pc, .o_retire_rd_wdata, .o_retire_rs1_raddr,
    .o_retire_rs2_raddr, .o_retire_rd_waddr
  );

  always #HALF_PERIOD clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // registers x1 to x7 only, so that dependences come up often
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = rand_next() % 32'd7 + 32'd1;
    return r[4:0];
  endfunction

  function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE}; // sw with base x0
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OP_LUI};
  endfunction

  // the fill depends on every address bit so that a wrong index shows up
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
  endfunction

  function automatic logic [31:0] imem_read(input logic [31:0] addr);
    return (addr[31:8] == 24'h0) ? imem[addr[7:2]] : NOP_WORD; // past the array is a nop
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm, off;
    for (int i = 0; i < NUM_INSTS - 1; i++) begin
      r   = rand_next();
      rd  = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      f3  = r[10:8];
      off = 12'h100 + {4'b0, r[13:11], 5'b0}; // eight words so that loads hit earlier stores
      case (r[2:0])
        3'd2, 3'd3: begin
          if (f3 == 3'b001) imm = {7'h00, r[20:16]};
          else if (f3 == 3'b101) imm = {r[3] ? 7'h20 : 7'h00, r[20:16]}; // srli or srai
          else imm = r[27:16];
          imem[i] = imm_word(imm, rs1, f3, rd, OP_IMM);
        end
        3'd4: imem[i] = lui_word(r[31:12], rd);
        3'd5: imem[i] = store_word(off, rs2);
        3'd6: imem[i] = imm_word(off, 5'd0, 3'b010, rd, OP_LOAD);
        default: imem[i] = op_word((r[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                                   rs2, rs1, f3, rd);
      endcase
    end
    imem[NUM_INSTS - 1] = EBREAK_WORD;
  endtask

  // rv32i arithmetic where alt selects sub and sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes the next instruction on the architectural state, one call per retire
  function automatic retire_t model_step();
    retire_t     r;
    logic [31:0] inst, a, b, imm_i, imm_s, addr;
    r      = '0;
    inst   = imem_read(model_pc);
    r.pc   = model_pc;
    r.inst = inst;
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    case (inst[6:0])
      OP_REG: begin
        r.rs1     = inst[19:15];
        r.rs2     = inst[24:20];
        r.rd      = inst[11:7];
        r.rd_data = alu_ref(inst[14:12], inst[30], a, b);
      end
      OP_IMM: begin
        r.rs1     = inst[19:15];
        r.rd      = inst[11:7];
        r.rd_data = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
      end
      OP_LUI: begin
        r.rd      = inst[11:7];
        r.rd_data = {inst[31:12], 12'b0};
      end
      OP_LOAD: begin
        addr      = a + imm_i;
        r.rs1     = inst[19:15];
        r.rd      = inst[11:7];
        r.rd_data = (addr[31:8] == 24'h1) ? model_dmem[addr[7:2]] : 32'hDEAD_BEEF;
      end
      OP_STORE: begin
        r.rs1      = inst[19:15];
        r.rs2      = inst[24:20];
        r.is_store = 1'b1;
        r.st_addr  = a + imm_s;
        r.st_data  = b;
        if (r.st_addr[31:8] == 24'h1) model_dmem[r.st_addr[7:2]] = b;
      end
      default: r.halt = (inst == EBREAK_WORD);
    endcase
    if (r.rd != 5'd0) model_regs[r.rd] = r.rd_data;
    model_pc = model_pc + 32'd4; // straight-line code only
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // both memories answer from the addresses set at the last edge
  always @(posedge clk) begin
    #2;
    i_imem_rdata = imem_read(o_imem_raddr);
    // dmem holds its data back unless a load reads it
    i_dmem_rdata = (o_dmem_ren && (o_dmem_addr[31:8] == 24'h1)) ? dmem[o_dmem_addr[7:2]]
                                                                 : 32'hDEAD_BEEF;
  end

  // outputs are sampled mid-cycle, well away from the driving edge
  always @(negedge clk) begin
    if (!i_rst && !halt_seen) begin
      if (o_dmem_ren && o_dmem_wen) begin
        $display("ERROR: dmem read and write both enabled at address %h", o_dmem_addr);
        errors++;
      end
      if (o_dmem_wen) begin
        store_addr_q.push_back(o_dmem_addr);
        store_data_q.push_back(o_dmem_wdata);
        if (o_dmem_addr[31:8] == 24'h1) dmem[o_dmem_addr[7:2]] = o_dmem_wdata;
      end
      if (o_retire_valid) begin
        expected = model_step();
        retired++;
        check_value("o_retire_pc", o_retire_pc, expected.pc);
        check_value("o_retire_inst", o_retire_inst, expected.inst);
        check_value("o_retire_rd_waddr", {27'b0, o_retire_rd_waddr}, {27'b0, expected.rd});
        check_value("o_retire_rs1_raddr", {27'b0, o_retire_rs1_raddr}, {27'b0, expected.rs1});
        check_value("o_retire_rs2_raddr", {27'b0, o_retire_rs2_raddr}, {27'b0, expected.rs2});
        check_value("o_retire_halt", {31'b0, o_retire_halt}, {31'b0, expected.halt});
        if (expected.rd != 5'd0) check_value("o_retire_rd_wdata", o_retire_rd_wdata,
                                             expected.rd_data);
        if (expected.is_store && store_addr_q.size() == 0) begin
          $display("ERROR: store at pc %h retired without a dmem write", expected.pc);
          errors++;
        end else if (expected.is_store) begin
          check_value("o_dmem_addr", store_addr_q.pop_front(), expected.st_addr);
          check_value("o_dmem_wdata", store_data_q.pop_front(), expected.st_data);
        end
        if (o_retire_halt) halt_seen = 1'b1;
      end
    end
  end

  initial begin
    clk          = 1'b0;
    i_rst        = 1'b1;
    i_imem_rdata = NOP_WORD;
    i_dmem_rdata = 32'h0;
    rng_state    = SEED;
    model_pc     = RESET_ADDR;
    halt_seen    = 1'b0;
    errors       = 0;
    checks       = 0;
    retired      = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'h0;
    for (int i = 0; i < 64; i++) begin
      imem[i]       = NOP_WORD;
      dmem[i]       = fill_word(32'h100 + i * 4);
      model_dmem[i] = dmem[i];
    end
    build_program();
    // the last pass also covers the first cycle after release, the first fetch
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #2;
      if (i == RESET_CYCLES - 1) i_rst = 1'b0;
      @(negedge clk);
      check_value("o_retire_valid", {31'b0, o_retire_valid}, 32'd0);
      check_value("o_dmem_ren", {31'b0, o_dmem_ren}, 32'd0);
      check_value("o_dmem_wen", {31'b0, o_dmem_wen}, 32'd0);
      check_value("o_imem_raddr", o_imem_raddr, RESET_ADDR);
    end
    cycles = RESET_CYCLES;
    while (!halt_seen && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!halt_seen) begin
      $display("ERROR: timed out before halt after %0d cycles", cycles);
      errors++;
    end else begin
      check_value("retired count", retired, NUM_INSTS);
      for (int i = 0; i < 64; i++) check_value($sformatf("dmem[%0d]", i), dmem[i], model_dmem[i]);
      if (store_addr_q.size() != 0) begin
        $display("ERROR: %0d dmem writes had no retiring store", store_addr_q.size());
        errors++;
      end
    end
    $display("%0d checks, %0d errors, %0d instructions retired", checks, errors, retired);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* compile.f */
design/hart_pkg.sv
design/hart_fetch.sv
design/hart_regfile.sv
design/hart_hazard.sv
design/hart_decode.sv
design/hart_execute.sv
design/hart_mem_wb.sv
design/hart_top.sv
testbench/tb_hart.sv

/* Makefile */
# Verilator flow for the five-stage hart and its testbench

TOP := tb_hart
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): compile.f design/*.sv testbench/*.sv
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(OBJ) -f compile.f

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee run.log
	@grep -q "PASS: all tests" run.log

lint:
	verilator --lint-only -Wall --top-module hart_top design/hart_pkg.sv design/hart_fetch.sv design/hart_regfile.sv design/hart_hazard.sv design/hart_decode.sv design/hart_execute.sv design/hart_mem_wb.sv design/hart_top.sv

clean:
	rm -rf $(OBJ) run.log
